/* build.f */
+incdir+rtl
+incdir+test
rtl/exePkg.sv
rtl/alu.sv
rtl/branchUnit.sv
rtl/mulUnit.sv
rtl/dataMem.sv
rtl/exeStage.sv
test/exeStageTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module exeStageTb -o exeSim || exit 1
simOut=$(./obj_dir/exeSim)
echo "$simOut"
echo "$simOut" | grep -qx "PASS: all tests" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

/* test/exeTbTasks.svh */
`ifndef EXE_TB_TASKS_SVH
`define EXE_TB_TASKS_SVH

localparam int byteAw = $clog2(4 * `DMEM_WORDS);

// Byte image of the data RAM, wraps with the address like the RTL
logic [7:0] memBytes [4 * `DMEM_WORDS];

function automatic issuePkt_t bubble();
	issuePkt_t p;
	p = '0;
	p.aluFn = ALU_ADD;
	p.brFn = BR_NONE;
	p.mulOp = MUL_MUL;
	p.memOp = MEM_NONE;
	p.wbSel = WB_ALU;
	return p;
endfunction

// Register writing packet, the caller fills in the operation
function automatic issuePkt_t regPkt(wbSel_t sel, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
	logic [`REG_AW-1:0] rd);
	issuePkt_t p;
	p = bubble();
	p.wbSel = sel;
	p.opA = a;
	p.opB = b;
	p.rd = rd;
	p.we = 1'b1;
	return p;
endfunction

function automatic issuePkt_t branchPkt(brFn_t fn, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
	logic [`XLEN-1:0] pc, logic [`XLEN-1:0] bImm);
	issuePkt_t p;
	p = bubble();
	p.brFn = fn;
	p.opA = a;
	p.opB = b;
	p.pc = pc;
	p.bImm = bImm;
	return p;
endfunction

function automatic issuePkt_t memPkt(memOp_t op, logic [`XLEN-1:0] base, logic [`XLEN-1:0] off,
	logic [`XLEN-1:0] data, logic [`REG_AW-1:0] rd);
	issuePkt_t p;
	p = bubble();
	p.memOp = op;
	p.opA = base;
	if (op inside {MEM_SB, MEM_SH, MEM_SW})
	begin
		p.sImm = off;
		p.opB = data; // rs2 value to store
	end
	else
	begin
		p.opB = off;
		p.rd = rd;
		p.we = 1'b1;
		p.wbSel = WB_LOAD;
	end
	return p;
endfunction

// Store data that depends on every address bit
function automatic logic [`XLEN-1:0] fillWord(logic [`XLEN-1:0] addr);
	return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
endfunction

function automatic logic [`XLEN-1:0] aluModel(aluFn_t fn, logic [`XLEN-1:0] a,
	logic [`XLEN-1:0] b);
	logic [4:0] s;
	logic [`XLEN-1:0] val;
	s = b[4:0];
	case (fn)
		ALU_ADD:  val = a + b;
		ALU_SUB:  val = a + ~b + 32'd1;
		ALU_SLL:  val = a << s;
		ALU_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		ALU_SLTU: val = (a < b) ? 32'd1 : 32'd0;
		ALU_XOR:  val = a ^ b;
		ALU_SRL:  val = a >> s;
		ALU_SRA:  val = (a >> s) | (a[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0); // Sign fill
		ALU_OR:   val = a | b;
		ALU_AND:  val = a & b;
		default:  val = '0;
	endcase
	return val;
endfunction

function automatic logic brModel(brFn_t fn, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
	logic taken;
	case (fn)
		BR_BEQ:  taken = (a == b);
		BR_BNE:  taken = (a != b);
		BR_BLT:  taken = ($signed(a) < $signed(b));
		BR_BGE:  taken = ($signed(a) >= $signed(b));
		BR_BLTU: taken = (a < b);
		BR_BGEU: taken = (a >= b);
		default: taken = 1'b0;
	endcase
	return taken;
endfunction

function automatic logic [`XLEN-1:0] mulModel(mulOp_t op, logic [`XLEN-1:0] a,
	logic [`XLEN-1:0] b);
	longint sa;
	longint ub;
	logic [63:0] prod;
	sa = longint'($signed(a));
	ub = longint'({32'h0, b});
	case (op)
		MUL_MULH:   prod = sa * longint'($signed(b));
		MUL_MULHSU: prod = sa * ub;
		default:    prod = {32'h0, a} * {32'h0, b};
	endcase
	return (op == MUL_MUL) ? prod[31:0] : prod[63:32];
endfunction

function automatic logic misModel(memOp_t op, logic [`XLEN-1:0] addr);
	logic bad;
	case (op)
		MEM_LH, MEM_LHU, MEM_SH: bad = (addr % 2 != 0);
		MEM_LW, MEM_SW:          bad = (addr % 4 != 0);
		default:                 bad = 1'b0;
	endcase
	return bad;
endfunction

function automatic logic [7:0] byteAt(logic [`XLEN-1:0] addr);
	return memBytes[addr[byteAw-1:0]];
endfunction

function automatic logic [`XLEN-1:0] loadModel(memOp_t op, logic [`XLEN-1:0] addr);
	logic [7:0] b0;
	logic [7:0] b1;
	logic [`XLEN-1:0] val;
	b0 = byteAt(addr);
	b1 = byteAt(addr + 32'd1);
	case (op)
		MEM_LB:  val = {{24{b0[7]}}, b0};
		MEM_LBU: val = {24'h0, b0};
		MEM_LH:  val = {{16{b1[7]}}, b1, b0};
		MEM_LHU: val = {16'h0, b1, b0};
		MEM_LW:  val = {byteAt(addr + 32'd3), byteAt(addr + 32'd2), b1, b0}; // Little endian
		default: val = '0;
	endcase
	return val;
endfunction

task automatic storeModel(input memOp_t op, input logic [`XLEN-1:0] addr,
	input logic [`XLEN-1:0] data);
	int n;
	logic [`XLEN-1:0] x;
	n = (op == MEM_SW) ? 4 : (op == MEM_SH) ? 2 : 1;
	for (int i = 0; i < n; i++)
	begin
		x = addr + 32'(i);
		memBytes[x[byteAw-1:0]] = data[8*i +: 8];
	end
endtask

// Expected redirect and writeback for one packet, in program order
task automatic predict(input issuePkt_t p, output redirectPkt_t r, output wbPkt_t w);
	logic isStore;
	logic [`XLEN-1:0] addr;
	logic [`XLEN-1:0] sum;
	isStore = (p.memOp inside {MEM_SB, MEM_SH, MEM_SW});
	addr = p.opA + (isStore ? p.sImm : p.opB);
	sum = p.opA + p.opB;
	r.take = p.jal || p.jalr || brModel(p.brFn, p.opA, p.opB);
	if (!r.take)
		r.target = '0;
	else if (p.jalr)
		r.target = sum & ~32'd1;
	else if (p.jal)
		r.target = p.pc + p.jImm;
	else
		r.target = p.pc + p.bImm;
	w.rd = p.rd;
	w.we = p.we;
	w.misaligned = misModel(p.memOp, addr);
	case (p.wbSel)
		WB_ALU:   w.data = aluModel(p.aluFn, p.opA, p.opB);
		WB_LINK:  w.data = p.pc + 32'd4;
		WB_MUL:   w.data = mulModel(p.mulOp, p.opA, p.opB);
		WB_LUI:   w.data = p.uImm;
		WB_LOAD:  w.data = w.misaligned ? '0 : loadModel(p.memOp, addr);
		WB_AUIPC: w.data = p.pc + p.uImm;
		default:  w.data = '0;
	endcase
	if (isStore && !w.misaligned)
		storeModel(p.memOp, addr, p.opB);
endtask

task automatic reportMismatch(input string name, input logic [`XLEN-1:0] expVal,
	input logic [`XLEN-1:0] actVal);
	$display("mismatch at %0t: %s expected %h got %h (%s test)", $time, name, expVal, actVal,
		curTest);
endtask

// Data and rd only matter when the register file writes
task automatic checkWb(input wbPkt_t exp, input wbPkt_t act);
	if (act.we !== exp.we)
	begin
		reportMismatch("wb.we", 32'(exp.we), 32'(act.we));
		wbErrs++;
	end
	if (act.misaligned !== exp.misaligned)
	begin
		reportMismatch("wb.misaligned", 32'(exp.misaligned), 32'(act.misaligned));
		wbErrs++;
	end
	if (exp.we && act.rd !== exp.rd)
	begin
		reportMismatch("wb.rd", 32'(exp.rd), 32'(act.rd));
		wbErrs++;
	end
	if (exp.we && act.data !== exp.data)
	begin
		reportMismatch("wb.data", exp.data, act.data);
		wbErrs++;
	end
endtask

task automatic checkRedirect(input redirectPkt_t exp, input redirectPkt_t act);
	if (act.take !== exp.take)
	begin
		reportMismatch("redirect.take", 32'(exp.take), 32'(act.take));
		redirErrs++;
	end
	if (exp.take && act.target !== exp.target)
	begin
		reportMismatch("redirect.target", exp.target, act.target);
		redirErrs++;
	end
endtask

`endif

/* test/exeStageTb.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module exeStageTb;
	import exePkg::*;

	localparam int resetCycles = 5;
	localparam int aluReps = 4;
	// Reset, ALU, control, memory, misalignment, other sources, drain
	localparam int totalPkts = resetCycles + 10 * aluReps + 34 + 39 + 7 + 28 + 2;

	logic clk;
	logic nrst;
	issuePkt_t issue;
	redirectPkt_t redirect;
	wbPkt_t wb;

	int seed = 49440;
	int wbErrs;
	int redirErrs;
	string curTest;

	// Pending expectations, one deep for redirect and two deep for wb
	redirectPkt_t expRedir[$];
	wbPkt_t expWb[$];

	logic [`XLEN-1:0] pairA [5] = '{32'd7, 32'hFFFF_FFFB, 32'd3, 32'd2, 32'd9};
	logic [`XLEN-1:0] pairB [5] = '{32'd7, 32'd3, 32'hFFFF_FFFB, 32'd9, 32'd2};
	logic [`XLEN-1:0] mulEdgeA [3] = '{32'h8000_0000, 32'h8000_0000, 32'hFFFF_FFFF};
	logic [`XLEN-1:0] mulEdgeB [3] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF};

	`include "exeTbTasks.svh"

	exeStage dut
	(
		.clk      (clk),
		.nrst     (nrst),
		.issue    (issue),
		.redirect (redirect),
		.wb       (wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Checks the outputs due now, then drives the next packet
	task automatic sendPkt(input issuePkt_t pkt);
		redirectPkt_t rDue;
		wbPkt_t wDue;
		redirectPkt_t rNew;
		wbPkt_t wNew;
		@(posedge clk);
		#2;
		rDue = expRedir.pop_front();
		wDue = expWb.pop_front();
		checkRedirect(rDue, redirect);
		checkWb(wDue, wb);
		predict(pkt, rNew, wNew);
		issue = pkt;
		expRedir.push_back(rNew);
		expWb.push_back(wNew);
	endtask

	task automatic resetTest();
		wbPkt_t idleW;
		redirectPkt_t idleR;
		curTest = "reset";
		idleW = '0;
		idleR = '0;
		checkWb(idleW, wb);
		checkRedirect(idleR, redirect);
		expRedir.push_back(idleR); // Still reset contents on the first sends
		expWb.push_back(idleW);
		expWb.push_back(idleW);
	endtask

	task automatic aluTest();
		issuePkt_t p;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		curTest = "alu";
		for (int f = 0; f < 10; f++)
		begin
			for (int r = 0; r < aluReps; r++)
			begin
				a = $random(seed);
				b = $random(seed);
				p = regPkt(WB_ALU, a, b, 5'(f + r));
				p.aluFn = aluFn_t'(f);
				sendPkt(p);
			end
		end
	endtask

	task automatic controlTest();
		issuePkt_t p;
		logic [`XLEN-1:0] pc;
		curTest = "control";
		// Equal, signed less and signed greater pairs for every condition
		for (int f = 1; f <= 6; f++)
		begin
			for (int k = 0; k < 5; k++)
			begin
				pc = 32'h1000 + 32'(64 * f + 4 * k);
				sendPkt(branchPkt(brFn_t'(f), pairA[k], pairB[k], pc,
					(k % 2 == 0) ? 32'h40 : 32'hFFFF_FFF0));
			end
		end
		p = regPkt(WB_LINK, 32'h0, 32'h0, 5'd1);
		p.jal = 1'b1;
		p.pc = 32'h2000;
		p.jImm = 32'h800;
		sendPkt(p);
		p.pc = 32'h3004;
		p.jImm = 32'hFFFF_F000; // Backwards jump
		sendPkt(p);
		p = regPkt(WB_LINK, 32'h2003, 32'h10, 5'd3);
		p.jalr = 1'b1;
		p.pc = 32'h2100;
		sendPkt(p);
		p.opA = 32'h3000;
		p.opB = 32'hFFFF_FFFF;
		sendPkt(p);
	endtask

	task automatic memTest();
		curTest = "memory";
		for (int i = 0; i < 8; i++)
			sendPkt(memPkt(MEM_SW, 32'h100, 32'(4 * i), fillWord(32'h100 + 32'(4 * i)), 5'd0));
		for (int k = 0; k < 4; k++)
		begin
			sendPkt(memPkt(MEM_LB, 32'h104, 32'(k), 32'h0, 5'(k + 1)));
			sendPkt(memPkt(MEM_LBU, 32'h104, 32'(k), 32'h0, 5'(k + 5)));
		end
		for (int k = 0; k < 4; k += 2)
		begin
			sendPkt(memPkt(MEM_LH, 32'h104, 32'(k), 32'h0, 5'(k + 9)));
			sendPkt(memPkt(MEM_LHU, 32'h104, 32'(k), 32'h0, 5'(k + 10)));
		end
		sendPkt(memPkt(MEM_LW, 32'h104, 32'h0, 32'h0, 5'd13));
		sendPkt(memPkt(MEM_LW, 32'h100, 32'h1C, 32'h0, 5'd14));
		// Narrow stores into filled words
		sendPkt(memPkt(MEM_SB, 32'h108, 32'h1, 32'h0000_00A5, 5'd0));
		sendPkt(memPkt(MEM_SH, 32'h10C, 32'h2, 32'h1234_8001, 5'd0));
		sendPkt(memPkt(MEM_LB, 32'h108, 32'h1, 32'h0, 5'd15));
		sendPkt(memPkt(MEM_LBU, 32'h108, 32'h1, 32'h0, 5'd16));
		sendPkt(memPkt(MEM_LW, 32'h108, 32'h0, 32'h0, 5'd17));
		sendPkt(memPkt(MEM_LH, 32'h10C, 32'h2, 32'h0, 5'd18));
		sendPkt(memPkt(MEM_LHU, 32'h10C, 32'h2, 32'h0, 5'd19));
		sendPkt(memPkt(MEM_LW, 32'h10C, 32'h0, 32'h0, 5'd20));
		// Store then load on the next cycle
		sendPkt(memPkt(MEM_SW, 32'h110, 32'h0, 32'hDEAD_BEEF, 5'd0));
		sendPkt(memPkt(MEM_LW, 32'h110, 32'h0, 32'h0, 5'd21));
		sendPkt(memPkt(MEM_SB, 32'h110, 32'h3, 32'h0000_007F, 5'd0));
		sendPkt(memPkt(MEM_LW, 32'h110, 32'h0, 32'h0, 5'd22));
		sendPkt(memPkt(MEM_SH, 32'h114, 32'h0, 32'hFFFF_9ABC, 5'd0));
		sendPkt(memPkt(MEM_LH, 32'h114, 32'h0, 32'h0, 5'd23));
		// Word index wraps at the RAM depth
		sendPkt(memPkt(MEM_SW, 32'h400, 32'h18, 32'h0BAD_F00D, 5'd0));
		sendPkt(memPkt(MEM_LW, 32'h0, 32'h18, 32'h0, 5'd24));
		sendPkt(memPkt(MEM_LW, 32'h400, 32'h18, 32'h0, 5'd25));
	endtask

	task automatic misalignTest();
		curTest = "misalignment";
		sendPkt(memPkt(MEM_SW, 32'h200, 32'h0, fillWord(32'h200), 5'd0));
		sendPkt(memPkt(MEM_SH, 32'h200, 32'h1, 32'hFFFF_FFFF, 5'd0));
		sendPkt(memPkt(MEM_SW, 32'h200, 32'h2, 32'hFFFF_FFFF, 5'd0));
		sendPkt(memPkt(MEM_LH, 32'h200, 32'h3, 32'h0, 5'd4));
		sendPkt(memPkt(MEM_LW, 32'h200, 32'h1, 32'h0, 5'd5));
		sendPkt(memPkt(MEM_LHU, 32'h200, 32'h1, 32'h0, 5'd6));
		sendPkt(memPkt(MEM_LW, 32'h200, 32'h0, 32'h0, 5'd7)); // Word must be untouched
	endtask

	task automatic wbSourceTest();
		issuePkt_t p;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] r;
		curTest = "writeback sources";
		for (int m = 0; m < 4; m++)
		begin
			for (int k = 0; k < 6; k++)
			begin
				if (k < 3)
				begin
					a = mulEdgeA[k];
					b = mulEdgeB[k];
				end
				else
				begin
					a = $random(seed);
					b = $random(seed);
				end
				p = regPkt(WB_MUL, a, b, 5'(k + 10));
				p.mulOp = mulOp_t'(m);
				sendPkt(p);
			end
		end
		for (int k = 0; k < 2; k++)
		begin
			r = $random(seed);
			p = regPkt(WB_LUI, 32'h0, 32'h0, 5'(k + 20));
			p.uImm = {r[19:0], 12'h000};
			sendPkt(p);
			p.wbSel = WB_AUIPC;
			p.pc = 32'h4000 + 32'(8 * k);
			sendPkt(p);
		end
	endtask

	initial
	begin
		nrst = 1'b0;
		issue = bubble();
		wbErrs = 0;
		redirErrs = 0;
		curTest = "reset";
		repeat (resetCycles) @(posedge clk);
		#2;
		nrst = 1'b1;
		resetTest();
		aluTest();
		controlTest();
		memTest();
		misalignTest();
		wbSourceTest();
		sendPkt(bubble()); // Flush the last expectations
		sendPkt(bubble());
		$display("errors: wb %0d, redirect %0d, total %0d", wbErrs, redirErrs,
			wbErrs + redirErrs);
		if (wbErrs + redirErrs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#(totalPkts * 20 + 1000);
		$display("timeout: the tests did not finish within the watchdog limit");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* rtl/exeStage.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module exeStage
(
	input logic clk,
	input logic nrst,
	input exePkg::issuePkt_t issue,
	output exePkg::redirectPkt_t redirect,
	output exePkg::wbPkt_t wb
);
	import exePkg::*;

	// Contents of the writeback pipeline register
	typedef struct packed {
		logic [`REG_AW-1:0] rd;
		logic we;
		wbSel_t wbSel;
		logic [`XLEN-1:0] aluRes;
		logic [`XLEN-1:0] mulRes;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] uImm;
		logic [`XLEN-1:0] auipcSum;
	} wbStage_t;

	issuePkt_t ex;
	wbStage_t wbQ;

	logic [`XLEN-1:0] aluRes;
	logic [`XLEN-1:0] mulRes;
	logic [`XLEN-1:0] auipcSum;
	logic [`XLEN-1:0] loadData;
	logic brTaken;
	logic memMis;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			ex <= '0; // we low, no branch, no memory op
		else
			ex <= issue;
	end

	alu uAlu
	(
		.a       (ex.opA),
		.b       (ex.opB),
		.fn      (ex.aluFn),
		.brFn    (ex.brFn),
		.result  (aluRes),
		.brTaken (brTaken)
	);

	branchUnit uBranch
	(
		.pc       (ex.pc),
		.a        (ex.opA),
		.iImm     (ex.opB), // jalr offset travels in opB
		.bImm     (ex.bImm),
		.jImm     (ex.jImm),
		.jal      (ex.jal),
		.jalr     (ex.jalr),
		.brTaken  (brTaken),
		.redirect (redirect)
	);

	mulUnit uMul
	(
		.a      (ex.opA),
		.b      (ex.opB),
		.op     (ex.mulOp),
		.result (mulRes)
	);

	// Fed before the ex register, it keeps its own first stage
	dataMem uMem
	(
		.clk        (clk),
		.nrst       (nrst),
		.op         (issue.memOp),
		.base       (issue.opA),
		.src        (issue.opB),
		.sImm       (issue.sImm),
		.loadData   (loadData),
		.misaligned (memMis)
	);

	assign auipcSum = ex.pc + ex.uImm;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wbQ <= '0;
		else
		begin
			wbQ.rd <= ex.rd;
			wbQ.we <= ex.we;
			wbQ.wbSel <= ex.wbSel;
			wbQ.aluRes <= aluRes;
			wbQ.mulRes <= mulRes;
			wbQ.pc <= ex.pc;
			wbQ.uImm <= ex.uImm;
			wbQ.auipcSum <= auipcSum;
		end
	end

	always_comb
	begin
		case (wbQ.wbSel)
			WB_ALU:   wb.data = wbQ.aluRes;
			WB_LINK:  wb.data = wbQ.pc + `XLEN'(4); // Byte addressed return
			WB_MUL:   wb.data = wbQ.mulRes;
			WB_LUI:   wb.data = wbQ.uImm;
			WB_LOAD:  wb.data = loadData;
			WB_AUIPC: wb.data = wbQ.auipcSum;
			default:  wb.data = '0;
		endcase
		wb.rd = wbQ.rd;
		wb.we = wbQ.we;
		wb.misaligned = memMis;
	end

	// Load writeback must trace back to a load in the ex stage
	assert property (@(posedge clk) disable iff (!nrst)
		(wbQ.we && (wbQ.wbSel == WB_LOAD)) |->
		($past(ex.memOp) inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU}));

	// Fetch gets halfword aligned targets only
	assert property (@(posedge clk) disable iff (!nrst)
		redirect.take |-> !redirect.target[0]);

endmodule

/* rtl/dataMem.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module dataMem
(
	input logic clk,
	input logic nrst,
	input exePkg::memOp_t op,
	input logic [`XLEN-1:0] base,
	input logic [`XLEN-1:0] src,
	input logic [`XLEN-1:0] sImm,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned
);
	import exePkg::*;

	localparam int idxBits = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] ram [`DMEM_WORDS];

	logic isStore;
	logic misNow;
	logic [`XLEN-1:0] addr;

	// Address stage
	memOp_t opQ;
	logic [idxBits-1:0] idxQ;
	logic [1:0] offQ;
	logic [`XLEN-1:0] dataQ;
	logic misQ;

	// Access stage
	memOp_t ldOpQ;
	logic [1:0] ldOffQ;
	logic [`XLEN-1:0] rdWordQ;
	logic misOutQ;

	logic wrEn;
	logic [3:0] byteEn;
	logic [`XLEN-1:0] wrData;
	logic [`XLEN-1:0] lanes;

	assign isStore = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
	assign addr = base + (isStore ? sImm : src); // src is the I immediate on loads

	always_comb
	begin
		case (op)
			MEM_LH, MEM_LHU, MEM_SH: misNow = addr[0];
			MEM_LW, MEM_SW:          misNow = (addr[1:0] != 2'b00);
			default:                 misNow = 1'b0;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opQ <= MEM_NONE;
			idxQ <= '0;
			offQ <= 2'b00;
			dataQ <= '0;
			misQ <= 1'b0;
			ldOpQ <= MEM_NONE;
			ldOffQ <= 2'b00;
			rdWordQ <= '0;
			misOutQ <= 1'b0;
		end
		else
		begin
			opQ <= op;
			idxQ <= addr[idxBits+1:2]; // Wraps modulo the RAM depth
			offQ <= addr[1:0];
			dataQ <= src;
			misQ <= misNow;
			ldOpQ <= opQ;
			ldOffQ <= offQ;
			rdWordQ <= ram[idxQ];
			misOutQ <= misQ;
		end
	end

	// Replicate store data across lanes, enable only the addressed bytes
	always_comb
	begin
		byteEn = 4'b0000;
		wrData = dataQ;
		case (opQ)
			MEM_SB:
			begin
				byteEn = 4'b0001 << offQ;
				wrData = {4{dataQ[7:0]}};
			end
			MEM_SH:
			begin
				byteEn = 4'b0011 << offQ;
				wrData = {2{dataQ[15:0]}};
			end
			MEM_SW: byteEn = 4'b1111;
			default: byteEn = 4'b0000;
		endcase
		if (misQ)
			byteEn = 4'b0000;
		wrEn = |byteEn;
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (wrEn && byteEn[i])
				ram[idxQ][8*i +: 8] <= wrData[8*i +: 8];
		end
	end

	always_comb
	begin
		lanes = rdWordQ >> {ldOffQ, 3'b000}; // Addressed byte down to lane 0
		case (ldOpQ)
			MEM_LB:  loadData = {{24{lanes[7]}}, lanes[7:0]};
			MEM_LBU: loadData = {24'b0, lanes[7:0]};
			MEM_LH:  loadData = {{16{lanes[15]}}, lanes[15:0]};
			MEM_LHU: loadData = {16'b0, lanes[15:0]};
			MEM_LW:  loadData = lanes;
			default: loadData = '0;
		endcase
		if (misOutQ)
			loadData = '0;
	end

	assign misaligned = misOutQ;

	// Misaligned access leaves its RAM word as it was
	assert property (@(posedge clk) disable iff (!nrst)
		misQ |=> (ram[$past(idxQ)] === $past(ram[idxQ])));

endmodule

/* rtl/mulUnit.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module mulUnit
(
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input exePkg::mulOp_t op,
	output logic [`XLEN-1:0] result
);
	import exePkg::*;

	logic aSigned;
	logic bSigned;
	logic [2*`XLEN-1:0] aWide;
	logic [2*`XLEN-1:0] bWide;
	logic [2*`XLEN-1:0] product;

	// MULHSU treats only a as signed
	assign aSigned = (op == MUL_MULH) || (op == MUL_MULHSU);
	assign bSigned = (op == MUL_MULH);

	assign aWide = {{`XLEN{aSigned & a[`XLEN-1]}}, a};
	assign bWide = {{`XLEN{bSigned & b[`XLEN-1]}}, b};

	// Low 64 bits of the extended product are exact for every variant
	assign product = aWide * bWide;

	always_comb
	begin
		if (op == MUL_MUL)
			result = product[`XLEN-1:0];
		else
			result = product[2*`XLEN-1:`XLEN]; // High word
	end

endmodule

/* rtl/branchUnit.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module branchUnit
(
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] iImm,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic jal,
	input logic jalr,
	input logic brTaken,
	output exePkg::redirectPkt_t redirect
);
	logic [`XLEN-1:0] jalrSum;

	assign jalrSum = a + iImm;

	always_comb
	begin
		redirect.take = jal | jalr | brTaken;
		if (!redirect.take)
			redirect.target = '0;
		else if (jalr)
			redirect.target = {jalrSum[`XLEN-1:1], 1'b0}; // Bit 0 dropped per jalr
		else if (jal)
			redirect.target = pc + jImm;
		else
			redirect.target = pc + bImm;
	end

	// Decode never marks both jump kinds at once
	always_comb
	begin
		assert final (!(jal && jalr));
	end

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps
`include "exe_defines.svh"

module alu
(
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input exePkg::aluFn_t fn,
	input exePkg::brFn_t brFn,
	output logic [`XLEN-1:0] result,
	output logic brTaken
);
	import exePkg::*;

	logic [4:0] shamt;
	logic isEq;
	logic isLt;
	logic isLtu;

	assign shamt = b[4:0]; // RV32 shifts use 5 bits
	assign isEq = (a == b);
	assign isLt = ($signed(a) < $signed(b));
	assign isLtu = (a < b);

	always_comb
	begin
		case (fn)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(`XLEN-1){1'b0}}, isLt};
			ALU_SLTU: result = {{(`XLEN-1){1'b0}}, isLtu};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt; // Arithmetic, keeps the sign
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

	// Branch compare shares the operands with the ALU
	always_comb
	begin
		case (brFn)
			BR_BEQ:  brTaken = isEq;
			BR_BNE:  brTaken = !isEq;
			BR_BLT:  brTaken = isLt;
			BR_BGE:  brTaken = !isLt;
			BR_BLTU: brTaken = isLtu;
			BR_BGEU: brTaken = !isLtu;
			default: brTaken = 1'b0;
		endcase
	end

endmodule

/* rtl/exePkg.sv */
`include "exe_defines.svh"

package exePkg;

	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} aluFn_t;

	// Branch condition, NONE for non-branches
	typedef enum logic [2:0]
	{
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6
	} brFn_t;

	typedef enum logic [1:0]
	{
		MUL_MUL    = 2'd0,
		MUL_MULH   = 2'd1,
		MUL_MULHSU = 2'd2,
		MUL_MULHU  = 2'd3
	} mulOp_t;

	typedef enum logic [3:0]
	{
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} memOp_t;

	typedef enum logic [2:0]
	{
		WB_ALU   = 3'd0,
		WB_LINK  = 3'd1,
		WB_MUL   = 3'd2,
		WB_LUI   = 3'd3,
		WB_LOAD  = 3'd4,
		WB_AUIPC = 3'd5
	} wbSel_t;

	// One decoded instruction from issue
	typedef struct packed {
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB; // I immediate for loads and jalr, rs2 otherwise
		logic [`REG_AW-1:0] rd;
		logic we;
		aluFn_t aluFn;
		brFn_t brFn;
		mulOp_t mulOp;
		memOp_t memOp;
		wbSel_t wbSel;
		logic jal;
		logic jalr;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] bImm;
		logic [`XLEN-1:0] jImm;
		logic [`XLEN-1:0] uImm; // Already shifted into the upper 20 bits
		logic [`XLEN-1:0] sImm;
	} issuePkt_t;

	typedef struct packed {
		logic [`XLEN-1:0] data;
		logic [`REG_AW-1:0] rd;
		logic we;
		logic misaligned;
	} wbPkt_t;

	typedef struct packed {
		logic take;
		logic [`XLEN-1:0] target;
	} redirectPkt_t;

endpackage

/* rtl/exe_defines.svh */
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Destination register index width
`define REG_AW 5

// Data RAM depth in 32-bit words
`define DMEM_WORDS 256

`endif
